//--- rtl/isaPkg.sv
package isaPkg;

    localparam int OPCODE_W = 4;
    localparam int FUNC_W = 6;

    typedef logic [OPCODE_W-1:0] opcodeT;
    typedef logic [FUNC_W-1:0] funcT;

    // major opcodes
    localparam opcodeT OP_BNE = 4'd0;
    localparam opcodeT OP_BEQ = 4'd1;
    localparam opcodeT OP_BGZ = 4'd2;
    localparam opcodeT OP_BLZ = 4'd3;
    localparam opcodeT OP_ADI = 4'd4;
    localparam opcodeT OP_ORI = 4'd5;
    localparam opcodeT OP_LHI = 4'd6;
    localparam opcodeT OP_LWD = 4'd7;
    localparam opcodeT OP_SWD = 4'd8;
    localparam opcodeT OP_JMP = 4'd9;
    localparam opcodeT OP_JAL = 4'd10;
    localparam opcodeT OP_ALU = 4'd15;   // register type, see func

    // function field of OP_ALU
    localparam funcT FN_ADD = 6'd0;
    localparam funcT FN_SUB = 6'd1;
    localparam funcT FN_AND = 6'd2;
    localparam funcT FN_ORR = 6'd3;
    localparam funcT FN_NOT = 6'd4;
    localparam funcT FN_TCP = 6'd5;
    localparam funcT FN_SHL = 6'd6;
    localparam funcT FN_SHR = 6'd7;
    localparam funcT FN_JPR = 6'd25;
    localparam funcT FN_JRL = 6'd26;
    localparam funcT FN_WWD = 6'd28;
    localparam funcT FN_HLT = 6'd29;

    // which stages an instruction walks through
    typedef enum logic [2:0]
    {
        PATH_SHORT,   // ID EX1 EX2
        PATH_WB,      // ... EX2 WB
        PATH_STORE,   // ... MEM1..MEM4
        PATH_LOAD,    // ... MEM1..MEM4 WB
        PATH_HALT     // ID EX1 then halt
    } pathT;

endpackage

//--- rtl/ctrlPkg.sv
package ctrlPkg;

    localparam int ALU_OP_W = 4;

    typedef logic [ALU_OP_W-1:0] aluOpT;
    localparam aluOpT ALU_ADD = 4'd0;
    localparam aluOpT ALU_SUB = 4'd1;
    localparam aluOpT ALU_AND = 4'd2;
    localparam aluOpT ALU_ORR = 4'd3;
    localparam aluOpT ALU_NOT = 4'd4;
    localparam aluOpT ALU_TCP = 4'd5;
    localparam aluOpT ALU_SHL = 4'd6;
    localparam aluOpT ALU_SHR = 4'd7;
    localparam aluOpT ALU_LHI = 4'd8;
    localparam aluOpT ALU_BNE = 4'd9;    // branch compares
    localparam aluOpT ALU_BEQ = 4'd10;
    localparam aluOpT ALU_BGZ = 4'd11;
    localparam aluOpT ALU_BLZ = 4'd12;

    typedef logic [1:0] srcBT;
    localparam srcBT SRCB_REG = 2'd0;
    localparam srcBT SRCB_ONE = 2'd1;    // shift by one
    localparam srcBT SRCB_IMM = 2'd2;
    localparam srcBT SRCB_ZERO = 2'd3;

    typedef logic [1:0] immSelT;
    localparam immSelT IMM_NONE = 2'd0;
    localparam immSelT IMM_SIGN8 = 2'd1;
    localparam immSelT IMM_TARGET12 = 2'd2;

    typedef logic [1:0] regDstT;
    localparam regDstT DST_RT = 2'd1;
    localparam regDstT DST_RD = 2'd2;
    localparam regDstT DST_LINK = 2'd3;  // r2 gets return address

    typedef enum logic [3:0]
    {
        ST_IDLE, ST_ID, ST_EX1, ST_EX2, ST_MEM1, ST_MEM2, ST_MEM3, ST_MEM4, ST_WB, ST_HALT
    } stageT;

endpackage

//--- rtl/decodedInstIf.sv
`timescale 1ns/1ps

interface decodedInstIf;

    logic loaded;
    isaPkg::pathT path;
    logic skipId;
    ctrlPkg::aluOpT aluOp;
    logic srcA;              // 1 register, 0 PC
    ctrlPkg::srcBT srcB;
    ctrlPkg::immSelT immSel;
    logic pcFromAlu;
    logic isBranch;
    logic isLoad;
    logic isStore;
    logic isWwd;
    logic writesReg;
    ctrlPkg::regDstT regDst;
    logic retire;            // last stage ends this cycle

    modport dec (output loaded, path, skipId, aluOp, srcA, srcB, immSel, pcFromAlu,
                 isBranch, isLoad, isStore, isWwd, writesReg, regDst, input retire);
    modport seq (input loaded, path, skipId, output retire);
    modport gen (input aluOp, srcA, srcB, immSel, pcFromAlu, isBranch, isLoad, isStore,
                 isWwd, writesReg, regDst, retire);

endinterface

//--- rtl/instDecoder.sv
`timescale 1ns/1ps

module instDecoder
(
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    output logic instReady,
    input  isaPkg::opcodeT opcode,
    input  isaPkg::funcT func,
    input  logic halted,
    decodedInstIf.dec dec
);

    logic accept;
    isaPkg::pathT nPath;
    logic nSkip;
    ctrlPkg::aluOpT nAluOp;
    logic nSrcA;
    ctrlPkg::srcBT nSrcB;
    ctrlPkg::immSelT nImm;
    logic nPcAlu;
    logic nBranch;
    logic nLoad;
    logic nStore;
    logic nWwd;
    logic nWrites;
    ctrlPkg::regDstT nDst;

    assign instReady = !dec.loaded && !halted;
    assign accept = instValid && instReady;

    always_comb
    begin
        nPath = isaPkg::PATH_SHORT;   // unknown codes run as no-op
        nSkip = 1'b0;
        nAluOp = ctrlPkg::ALU_ADD;
        nSrcA = 1'b0;
        nSrcB = ctrlPkg::SRCB_REG;
        nImm = ctrlPkg::IMM_NONE;
        nPcAlu = 1'b0;
        nBranch = 1'b0;
        nLoad = 1'b0;
        nStore = 1'b0;
        nWwd = 1'b0;
        nWrites = 1'b0;
        nDst = ctrlPkg::DST_RT;
        case (opcode)
            isaPkg::OP_ALU:
            begin
                case (func)
                    isaPkg::FN_ADD, isaPkg::FN_SUB, isaPkg::FN_AND, isaPkg::FN_ORR,
                    isaPkg::FN_NOT, isaPkg::FN_TCP, isaPkg::FN_SHL, isaPkg::FN_SHR:
                    begin
                        nPath = isaPkg::PATH_WB;
                        nSrcA = 1'b1;
                        nWrites = 1'b1;
                        nDst = ctrlPkg::DST_RD;
                        case (func)
                            isaPkg::FN_SUB: nAluOp = ctrlPkg::ALU_SUB;
                            isaPkg::FN_AND: nAluOp = ctrlPkg::ALU_AND;
                            isaPkg::FN_ORR: nAluOp = ctrlPkg::ALU_ORR;
                            isaPkg::FN_NOT: nAluOp = ctrlPkg::ALU_NOT;
                            isaPkg::FN_TCP: nAluOp = ctrlPkg::ALU_TCP;
                            isaPkg::FN_SHL: nAluOp = ctrlPkg::ALU_SHL;
                            isaPkg::FN_SHR: nAluOp = ctrlPkg::ALU_SHR;
                            default: nAluOp = ctrlPkg::ALU_ADD;
                        endcase
                        if (func == isaPkg::FN_SHL || func == isaPkg::FN_SHR)
                            nSrcB = ctrlPkg::SRCB_ONE;
                    end
                    isaPkg::FN_JPR, isaPkg::FN_JRL:
                    begin
                        nSrcA = 1'b1;
                        nSrcB = ctrlPkg::SRCB_ZERO;   // rs passes through as target
                        nPcAlu = 1'b1;
                        if (func == isaPkg::FN_JRL)
                        begin
                            nPath = isaPkg::PATH_WB;
                            nWrites = 1'b1;
                            nDst = ctrlPkg::DST_LINK;
                        end
                    end
                    isaPkg::FN_WWD:
                    begin
                        nSrcA = 1'b1;
                        nSrcB = ctrlPkg::SRCB_ZERO;
                        nWwd = 1'b1;
                    end
                    isaPkg::FN_HLT: nPath = isaPkg::PATH_HALT;
                    default: nPath = isaPkg::PATH_SHORT;
                endcase
            end
            isaPkg::OP_ADI, isaPkg::OP_ORI, isaPkg::OP_LHI, isaPkg::OP_LWD, isaPkg::OP_SWD:
            begin
                nSrcA = 1'b1;
                nSrcB = ctrlPkg::SRCB_IMM;
                nImm = ctrlPkg::IMM_SIGN8;
                nWrites = (opcode != isaPkg::OP_SWD);
                nLoad = (opcode == isaPkg::OP_LWD);
                nStore = (opcode == isaPkg::OP_SWD);
                if (opcode == isaPkg::OP_ORI)
                    nAluOp = ctrlPkg::ALU_ORR;
                else if (opcode == isaPkg::OP_LHI)
                    nAluOp = ctrlPkg::ALU_LHI;
                if (opcode == isaPkg::OP_LWD)
                    nPath = isaPkg::PATH_LOAD;
                else if (opcode == isaPkg::OP_SWD)
                    nPath = isaPkg::PATH_STORE;
                else
                    nPath = isaPkg::PATH_WB;
            end
            isaPkg::OP_BNE, isaPkg::OP_BEQ, isaPkg::OP_BGZ, isaPkg::OP_BLZ:
            begin
                nSrcA = 1'b1;
                nBranch = 1'b1;
                case (opcode)
                    isaPkg::OP_BNE: nAluOp = ctrlPkg::ALU_BNE;
                    isaPkg::OP_BEQ: nAluOp = ctrlPkg::ALU_BEQ;
                    isaPkg::OP_BGZ: nAluOp = ctrlPkg::ALU_BGZ;
                    default: nAluOp = ctrlPkg::ALU_BLZ;
                endcase
                if (opcode == isaPkg::OP_BGZ || opcode == isaPkg::OP_BLZ)
                    nSrcB = ctrlPkg::SRCB_ZERO;   // compare against zero
            end
            isaPkg::OP_JMP, isaPkg::OP_JAL:
            begin
                nPath = isaPkg::PATH_WB;
                nSkip = (opcode == isaPkg::OP_JMP);
                nSrcB = ctrlPkg::SRCB_IMM;
                nImm = ctrlPkg::IMM_TARGET12;
                nPcAlu = 1'b1;
                nWrites = (opcode == isaPkg::OP_JAL);
                nDst = ctrlPkg::DST_LINK;
            end
            default: nPath = isaPkg::PATH_SHORT;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            dec.loaded <= 1'b0;
        else if (accept)
            dec.loaded <= 1'b1;
        else if (dec.retire)
            dec.loaded <= 1'b0;
    end

    // decoded fields stand in for the instruction register
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dec.path <= nPath;
            dec.skipId <= nSkip;
            dec.aluOp <= nAluOp;
            dec.srcA <= nSrcA;
            dec.srcB <= nSrcB;
            dec.immSel <= nImm;
            dec.pcFromAlu <= nPcAlu;
            dec.isBranch <= nBranch;
            dec.isLoad <= nLoad;
            dec.isStore <= nStore;
            dec.isWwd <= nWwd;
            dec.writesReg <= nWrites;
            dec.regDst <= nDst;
        end
    end

    // a held instruction blocks the next one until the sequencer retires it
    noAcceptWhileHeld: assert property (@(posedge clk) disable iff (!rstN)
        (dec.loaded && !dec.retire) |=> !(instValid && instReady));

endmodule

//--- rtl/stageSequencer.sv
`timescale 1ns/1ps

module stageSequencer
(
    input  logic clk,
    input  logic rstN,
    decodedInstIf.seq seq,
    output ctrlPkg::stageT stage,
    output logic halted
);

    ctrlPkg::stageT stateQ;
    ctrlPkg::stageT stateD;

    // the walk starts in the cycle right after the handshake
    always_comb
    begin
        stage = stateQ;
        if (stateQ == ctrlPkg::ST_IDLE && seq.loaded)
            stage = seq.skipId ? ctrlPkg::ST_EX1 : ctrlPkg::ST_ID;
    end

    always_comb
    begin
        stateD = stage;
        seq.retire = 1'b0;
        case (stage)
            ctrlPkg::ST_ID: stateD = ctrlPkg::ST_EX1;
            ctrlPkg::ST_EX1:
            begin
                if (seq.path == isaPkg::PATH_HALT)
                    stateD = ctrlPkg::ST_HALT;   // only reset leaves it
                else
                    stateD = ctrlPkg::ST_EX2;
            end
            ctrlPkg::ST_EX2:
            begin
                if (seq.path == isaPkg::PATH_SHORT)
                begin
                    seq.retire = 1'b1;
                    stateD = ctrlPkg::ST_IDLE;
                end
                else if (seq.path == isaPkg::PATH_WB)
                    stateD = ctrlPkg::ST_WB;
                else
                    stateD = ctrlPkg::ST_MEM1;
            end
            ctrlPkg::ST_MEM1: stateD = ctrlPkg::ST_MEM2;
            ctrlPkg::ST_MEM2: stateD = ctrlPkg::ST_MEM3;
            ctrlPkg::ST_MEM3: stateD = ctrlPkg::ST_MEM4;
            ctrlPkg::ST_MEM4:
            begin
                if (seq.path == isaPkg::PATH_STORE)
                begin
                    seq.retire = 1'b1;
                    stateD = ctrlPkg::ST_IDLE;
                end
                else
                    stateD = ctrlPkg::ST_WB;
            end
            ctrlPkg::ST_WB:
            begin
                seq.retire = 1'b1;
                stateD = ctrlPkg::ST_IDLE;
            end
            default: stateD = stage;   // idle and halt hold
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            stateQ <= ctrlPkg::ST_IDLE;
        else
            stateQ <= stateD;
    end

    assign halted = (stateQ == ctrlPkg::ST_HALT);

    stateLegal: assert property (@(posedge clk) disable iff (!rstN)
        stateQ inside {ctrlPkg::ST_IDLE, ctrlPkg::ST_ID, ctrlPkg::ST_EX1, ctrlPkg::ST_EX2,
                       ctrlPkg::ST_MEM1, ctrlPkg::ST_MEM2, ctrlPkg::ST_MEM3,
                       ctrlPkg::ST_MEM4, ctrlPkg::ST_WB, ctrlPkg::ST_HALT});

    // retire ends a final stage and the decoder is empty a cycle later
    retireStage: assert property (@(posedge clk) disable iff (!rstN)
        seq.retire |-> (stage inside {ctrlPkg::ST_EX2, ctrlPkg::ST_MEM4, ctrlPkg::ST_WB})
            ##1 (stage == ctrlPkg::ST_IDLE));

endmodule

//--- rtl/ctrlSignalGen.sv
`timescale 1ns/1ps

module ctrlSignalGen
(
    input  ctrlPkg::stageT stage,
    decodedInstIf.gen gen,
    output logic pcWrite,
    output logic pcWriteCond,
    output logic pcFromAlu,
    output ctrlPkg::aluOpT aluOp,
    output logic aluSrcA,
    output ctrlPkg::srcBT aluSrcB,
    output ctrlPkg::immSelT immSel,
    output logic aluOutWrite,
    output logic memRead,
    output logic memWrite,
    output logic mdrWrite,
    output logic memToReg,
    output logic regWrite,
    output ctrlPkg::regDstT regDst,
    output logic wwd,
    output logic instDone,
    output logic halted
);

    always_comb
    begin
        pcWrite = 1'b0;
        pcWriteCond = 1'b0;
        pcFromAlu = 1'b0;
        aluOp = ctrlPkg::ALU_ADD;
        aluSrcA = 1'b0;
        aluSrcB = ctrlPkg::SRCB_REG;
        immSel = ctrlPkg::IMM_NONE;
        aluOutWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        mdrWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        regDst = '0;
        wwd = 1'b0;
        case (stage)
            ctrlPkg::ST_ID: aluOutWrite = gen.isBranch;   // branch target
            ctrlPkg::ST_EX1:
            begin
                aluOp = gen.aluOp;
                aluSrcA = gen.srcA;
                aluSrcB = gen.srcB;
                immSel = gen.immSel;
                wwd = gen.isWwd;
            end
            ctrlPkg::ST_EX2:
            begin
                pcWrite = gen.pcFromAlu;   // jumps take the ALU result
                pcFromAlu = gen.pcFromAlu;
                pcWriteCond = gen.isBranch;
                aluOutWrite = (gen.writesReg && !gen.pcFromAlu) || gen.isLoad || gen.isStore;
            end
            ctrlPkg::ST_MEM1: memRead = gen.isLoad;
            ctrlPkg::ST_MEM2:
            begin
                mdrWrite = gen.isLoad;
                memWrite = gen.isStore;
            end
            ctrlPkg::ST_WB:
            begin
                regWrite = gen.writesReg;
                if (gen.writesReg)
                    regDst = gen.regDst;
                memToReg = gen.isLoad;
            end
            default: regDst = '0;
        endcase
        // decoder never marks one instruction as both load and store
        memExclusive: assert (!(memRead && memWrite));
    end

    assign instDone = gen.retire;
    assign halted = (stage == ctrlPkg::ST_HALT);

endmodule

//--- rtl/mcCtrlTop.sv
`timescale 1ns/1ps

module mcCtrlTop
(
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    output logic instReady,
    input  isaPkg::opcodeT opcode,
    input  isaPkg::funcT func,
    output logic pcWrite,
    output logic pcWriteCond,
    output logic pcFromAlu,
    output ctrlPkg::aluOpT aluOp,
    output logic aluSrcA,
    output ctrlPkg::srcBT aluSrcB,
    output ctrlPkg::immSelT immSel,
    output logic aluOutWrite,
    output logic memRead,
    output logic memWrite,
    output logic mdrWrite,
    output logic memToReg,
    output logic regWrite,
    output ctrlPkg::regDstT regDst,
    output logic wwd,
    output logic instDone,
    output logic halted
);

    decodedInstIf instIf();
    ctrlPkg::stageT stage;
    logic seqHalted;   // blocks new instructions

    instDecoder uDecoder
    (
        .clk(clk),
        .rstN(rstN),
        .instValid(instValid),
        .instReady(instReady),
        .opcode(opcode),
        .func(func),
        .halted(seqHalted),
        .dec(instIf.dec)
    );

    stageSequencer uSequencer
    (
        .clk(clk),
        .rstN(rstN),
        .seq(instIf.seq),
        .stage(stage),
        .halted(seqHalted)
    );

    ctrlSignalGen uSignalGen
    (
        .stage(stage),
        .gen(instIf.gen),
        .pcWrite(pcWrite),
        .pcWriteCond(pcWriteCond),
        .pcFromAlu(pcFromAlu),
        .aluOp(aluOp),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .immSel(immSel),
        .aluOutWrite(aluOutWrite),
        .memRead(memRead),
        .memWrite(memWrite),
        .mdrWrite(mdrWrite),
        .memToReg(memToReg),
        .regWrite(regWrite),
        .regDst(regDst),
        .wwd(wwd),
        .instDone(instDone),
        .halted(halted)
    );

endmodule

//--- tb/mcCtrlTb.sv
`timescale 1ns/1ps

module mcCtrlTb;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INST = 400;
    localparam int HALT_HOLD = 20;
    localparam int TIMEOUT_CYCLES = NUM_INST * (8 + 3) + RESET_CYCLES + HALT_HOLD;

    logic clk;
    logic rstN;
    logic instValid;
    logic instReady;
    isaPkg::opcodeT opcode;
    isaPkg::funcT func;
    logic pcWrite, pcWriteCond, pcFromAlu, aluSrcA, aluOutWrite;
    logic memRead, memWrite, mdrWrite, memToReg, regWrite, wwd, instDone, halted;
    ctrlPkg::aluOpT aluOp;
    ctrlPkg::srcBT aluSrcB;
    ctrlPkg::immSelT immSel;
    ctrlPkg::regDstT regDst;

    // model of the instruction in flight
    isaPkg::pathT mPath;
    logic mSkip, mSrcA, mJump, mBranch, mLoad, mStore, mWwd, mWrites;
    ctrlPkg::aluOpT mAluOp;
    ctrlPkg::srcBT mSrcB;
    ctrlPkg::immSelT mImm;
    ctrlPkg::regDstT mDst;
    ctrlPkg::stageT stageList[$];

    // expected outputs for the sampled cycle
    logic ePcWrite, ePcWriteCond, ePcFromAlu, eSrcA, eAluOutWrite, eMemRead, eMemWrite;
    logic eMdrWrite, eMemToReg, eRegWrite, eWwd, eDone, eHalted, eReady;
    ctrlPkg::aluOpT eAluOp;
    ctrlPkg::srcBT eSrcB;
    ctrlPkg::immSelT eImm;
    ctrlPkg::regDstT eRegDst;

    logic [31:0] rngState = 32'h25a4a887;
    int errorCount = 0;
    int checkCount = 0;
    int idleCycles;
    logic [3:0] pick;
    isaPkg::opcodeT op;
    isaPkg::funcT fn;

    isaPkg::opcodeT opList [12] = '{isaPkg::OP_ALU, isaPkg::OP_ADI, isaPkg::OP_ORI,
        isaPkg::OP_LHI, isaPkg::OP_LWD, isaPkg::OP_SWD, isaPkg::OP_BNE, isaPkg::OP_BEQ,
        isaPkg::OP_BGZ, isaPkg::OP_BLZ, isaPkg::OP_JMP, isaPkg::OP_JAL};
    isaPkg::funcT fnList [12] = '{isaPkg::FN_ADD, isaPkg::FN_SUB, isaPkg::FN_AND,
        isaPkg::FN_ORR, isaPkg::FN_NOT, isaPkg::FN_TCP, isaPkg::FN_SHL, isaPkg::FN_SHR,
        isaPkg::FN_JPR, isaPkg::FN_JRL, isaPkg::FN_WWD, isaPkg::FN_HLT};

    mcCtrlTop DUT
    (
        .clk(clk), .rstN(rstN), .instValid(instValid), .instReady(instReady),
        .opcode(opcode), .func(func), .pcWrite(pcWrite), .pcWriteCond(pcWriteCond),
        .pcFromAlu(pcFromAlu), .aluOp(aluOp), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .immSel(immSel), .aluOutWrite(aluOutWrite), .memRead(memRead),
        .memWrite(memWrite), .mdrWrite(mdrWrite), .memToReg(memToReg),
        .regWrite(regWrite), .regDst(regDst), .wwd(wwd), .instDone(instDone),
        .halted(halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    task automatic setWb(input ctrlPkg::regDstT dst);
        mPath = isaPkg::PATH_WB;
        mWrites = 1'b1;
        mDst = dst;
    endtask

    task automatic regOp(input ctrlPkg::aluOpT aop, input ctrlPkg::srcBT srcB);
        mSrcA = 1'b1;
        mAluOp = aop;
        mSrcB = srcB;
        setWb(ctrlPkg::DST_RD);
    endtask

    // reference decode table for one instruction
    task automatic modelInst(input isaPkg::opcodeT o, input isaPkg::funcT f);
        mPath = isaPkg::PATH_SHORT;
        mSkip = 1'b0;
        mSrcA = 1'b0;
        mJump = 1'b0;
        mBranch = 1'b0;
        mLoad = 1'b0;
        mStore = 1'b0;
        mWwd = 1'b0;
        mWrites = 1'b0;
        mAluOp = ctrlPkg::ALU_ADD;
        mSrcB = ctrlPkg::SRCB_REG;
        mImm = ctrlPkg::IMM_NONE;
        mDst = ctrlPkg::DST_RT;
        case (o)
            isaPkg::OP_ALU:
                case (f)
                    isaPkg::FN_ADD: regOp(ctrlPkg::ALU_ADD, ctrlPkg::SRCB_REG);
                    isaPkg::FN_SUB: regOp(ctrlPkg::ALU_SUB, ctrlPkg::SRCB_REG);
                    isaPkg::FN_AND: regOp(ctrlPkg::ALU_AND, ctrlPkg::SRCB_REG);
                    isaPkg::FN_ORR: regOp(ctrlPkg::ALU_ORR, ctrlPkg::SRCB_REG);
                    isaPkg::FN_NOT: regOp(ctrlPkg::ALU_NOT, ctrlPkg::SRCB_REG);
                    isaPkg::FN_TCP: regOp(ctrlPkg::ALU_TCP, ctrlPkg::SRCB_REG);
                    isaPkg::FN_SHL: regOp(ctrlPkg::ALU_SHL, ctrlPkg::SRCB_ONE);
                    isaPkg::FN_SHR: regOp(ctrlPkg::ALU_SHR, ctrlPkg::SRCB_ONE);
                    isaPkg::FN_JPR, isaPkg::FN_JRL:
                    begin
                        mSrcA = 1'b1;
                        mSrcB = ctrlPkg::SRCB_ZERO;
                        mJump = 1'b1;
                        if (f == isaPkg::FN_JRL)
                            setWb(ctrlPkg::DST_LINK);
                    end
                    isaPkg::FN_WWD:
                    begin
                        mSrcA = 1'b1;
                        mSrcB = ctrlPkg::SRCB_ZERO;
                        mWwd = 1'b1;
                    end
                    isaPkg::FN_HLT: mPath = isaPkg::PATH_HALT;
                    default: mPath = isaPkg::PATH_SHORT;
                endcase
            isaPkg::OP_ADI, isaPkg::OP_ORI, isaPkg::OP_LHI, isaPkg::OP_LWD, isaPkg::OP_SWD:
            begin
                mSrcA = 1'b1;
                mSrcB = ctrlPkg::SRCB_IMM;
                mImm = ctrlPkg::IMM_SIGN8;
                if (o == isaPkg::OP_ORI)
                    mAluOp = ctrlPkg::ALU_ORR;
                if (o == isaPkg::OP_LHI)
                    mAluOp = ctrlPkg::ALU_LHI;
                if (o == isaPkg::OP_LWD)
                begin
                    mPath = isaPkg::PATH_LOAD;
                    mLoad = 1'b1;
                    mWrites = 1'b1;
                end
                else if (o == isaPkg::OP_SWD)
                begin
                    mPath = isaPkg::PATH_STORE;
                    mStore = 1'b1;
                end
                else
                    setWb(ctrlPkg::DST_RT);
            end
            isaPkg::OP_BNE, isaPkg::OP_BEQ, isaPkg::OP_BGZ, isaPkg::OP_BLZ:
            begin
                mSrcA = 1'b1;
                mBranch = 1'b1;
                if (o == isaPkg::OP_BNE)
                    mAluOp = ctrlPkg::ALU_BNE;
                else if (o == isaPkg::OP_BEQ)
                    mAluOp = ctrlPkg::ALU_BEQ;
                else
                begin
                    mAluOp = (o == isaPkg::OP_BGZ) ? ctrlPkg::ALU_BGZ : ctrlPkg::ALU_BLZ;
                    mSrcB = ctrlPkg::SRCB_ZERO;   // compare with zero
                end
            end
            isaPkg::OP_JMP, isaPkg::OP_JAL:
            begin
                mSrcB = ctrlPkg::SRCB_IMM;
                mImm = ctrlPkg::IMM_TARGET12;
                mJump = 1'b1;
                setWb(ctrlPkg::DST_LINK);
                mWrites = (o == isaPkg::OP_JAL);
                mSkip = (o == isaPkg::OP_JMP);
            end
            default: mPath = isaPkg::PATH_SHORT;
        endcase
    endtask

    task automatic buildStages();
        stageList.delete();
        if (!mSkip)
            stageList.push_back(ctrlPkg::ST_ID);
        stageList.push_back(ctrlPkg::ST_EX1);
        if (mPath != isaPkg::PATH_HALT)
            stageList.push_back(ctrlPkg::ST_EX2);
        if (mPath == isaPkg::PATH_STORE || mPath == isaPkg::PATH_LOAD)
        begin
            stageList.push_back(ctrlPkg::ST_MEM1);
            stageList.push_back(ctrlPkg::ST_MEM2);
            stageList.push_back(ctrlPkg::ST_MEM3);
            stageList.push_back(ctrlPkg::ST_MEM4);
        end
        if (mPath == isaPkg::PATH_WB || mPath == isaPkg::PATH_LOAD)
            stageList.push_back(ctrlPkg::ST_WB);
    endtask

    task automatic expectStage(input ctrlPkg::stageT st, input logic last);
        ePcWrite = 1'b0;
        ePcWriteCond = 1'b0;
        ePcFromAlu = 1'b0;
        eSrcA = 1'b0;
        eAluOutWrite = 1'b0;
        eMemRead = 1'b0;
        eMemWrite = 1'b0;
        eMdrWrite = 1'b0;
        eMemToReg = 1'b0;
        eRegWrite = 1'b0;
        eWwd = 1'b0;
        eAluOp = ctrlPkg::ALU_ADD;
        eSrcB = ctrlPkg::SRCB_REG;
        eImm = ctrlPkg::IMM_NONE;
        eRegDst = '0;
        eDone = last;
        eHalted = (st == ctrlPkg::ST_HALT);
        eReady = (st == ctrlPkg::ST_IDLE);
        case (st)
            ctrlPkg::ST_ID: eAluOutWrite = mBranch;
            ctrlPkg::ST_EX1:
            begin
                eAluOp = mAluOp;
                eSrcA = mSrcA;
                eSrcB = mSrcB;
                eImm = mImm;
                eWwd = mWwd;
            end
            ctrlPkg::ST_EX2:
            begin
                ePcWrite = mJump;
                ePcFromAlu = mJump;
                ePcWriteCond = mBranch;
                eAluOutWrite = (mPath == isaPkg::PATH_WB && !mJump) || mLoad || mStore;
            end
            ctrlPkg::ST_MEM1: eMemRead = mLoad;
            ctrlPkg::ST_MEM2:
            begin
                eMdrWrite = mLoad;
                eMemWrite = mStore;
            end
            ctrlPkg::ST_WB:
            begin
                eRegWrite = mWrites;
                eRegDst = mWrites ? mDst : '0;
                eMemToReg = mLoad;
            end
            default: eDone = last;
        endcase
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic checkField(input string name, input logic [3:0] got, input logic [3:0] exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic compareAll();
        checkBit("instReady", instReady, eReady);
        checkBit("instDone", instDone, eDone);
        checkBit("halted", halted, eHalted);
        checkBit("pcWrite", pcWrite, ePcWrite);
        checkBit("pcWriteCond", pcWriteCond, ePcWriteCond);
        checkBit("pcFromAlu", pcFromAlu, ePcFromAlu);
        checkField("aluOp", aluOp, eAluOp);
        checkBit("aluSrcA", aluSrcA, eSrcA);
        checkField("aluSrcB", 4'(aluSrcB), 4'(eSrcB));
        checkField("immSel", 4'(immSel), 4'(eImm));
        checkBit("aluOutWrite", aluOutWrite, eAluOutWrite);
        checkBit("memRead", memRead, eMemRead);
        checkBit("memWrite", memWrite, eMemWrite);
        checkBit("mdrWrite", mdrWrite, eMdrWrite);
        checkBit("memToReg", memToReg, eMemToReg);
        checkBit("regWrite", regWrite, eRegWrite);
        checkField("regDst", 4'(regDst), 4'(eRegDst));
        checkBit("wwd", wwd, eWwd);
    endtask

    task automatic nextDriveSlot();
        @(posedge clk);
        #1;
    endtask

    task automatic pickInst(input logic last);
        if (last)
        begin
            op = isaPkg::OP_ALU;
            fn = isaPkg::FN_HLT;
        end
        else
        begin
            op = isaPkg::OP_ALU;
            fn = isaPkg::FN_HLT;
            while (op == isaPkg::OP_ALU && fn == isaPkg::FN_HLT)   // halt only at the end
            begin
                pick = 4'(nextRandom() % 12);
                op = opList[pick];
                pick = 4'(nextRandom() % 12);
                fn = (op == isaPkg::OP_ALU) ? fnList[pick] : 6'(nextRandom());
            end
        end
    endtask

    initial
    begin
        rstN = 1'b0;
        instValid = 1'b0;
        opcode = '0;
        func = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;
        @(negedge clk);
        expectStage(ctrlPkg::ST_IDLE, 1'b0);
        compareAll();
        for (int n = 0; n < NUM_INST; n++)
        begin
            pickInst(n == NUM_INST - 1);
            idleCycles = int'(nextRandom() % 4);
            repeat (idleCycles)
            begin
                nextDriveSlot();
                instValid = 1'b0;
                @(negedge clk);
                expectStage(ctrlPkg::ST_IDLE, 1'b0);
                compareAll();
            end
            nextDriveSlot();
            instValid = 1'b1;
            opcode = op;
            func = fn;
            @(negedge clk);
            expectStage(ctrlPkg::ST_IDLE, 1'b0);
            compareAll();
            while (!instReady)
            begin
                nextDriveSlot();
                @(negedge clk);
            end
            modelInst(op, fn);
            buildStages();
            foreach (stageList[k])
            begin
                nextDriveSlot();
                if (k == 0)
                begin
                    instValid = 1'b0;
                    opcode = 4'(nextRandom());   // decoder must hold its own copy
                    func = 6'(nextRandom());
                end
                @(negedge clk);
                expectStage(stageList[k],
                    k == stageList.size() - 1 && mPath != isaPkg::PATH_HALT);
                compareAll();
            end
        end
        // offers are ignored once halted
        repeat (HALT_HOLD)
        begin
            nextDriveSlot();
            instValid = 1'b1;
            opcode = isaPkg::OP_ADI;
            @(negedge clk);
            expectStage(ctrlPkg::ST_HALT, 1'b0);
            compareAll();
        end
        $display("checks: %0d errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d errors: %0d", checkCount, errorCount);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- mcCtrl.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/decodedInstIf.sv
rtl/instDecoder.sv
rtl/stageSequencer.sv
rtl/ctrlSignalGen.sv
rtl/mcCtrlTop.sv
tb/mcCtrlTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mcCtrlTb
FILELIST ?= mcCtrl.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
